//--- logic/jtmini_consts.svh
// Board geometry, pixel divider and memory map; GFX_BASE and PAL_START must keep their alignment
`ifndef JTMINI_CONSTS_SVH
`define JTMINI_CONSTS_SVH

// Video geometry in pixels and lines
`define JTMINI_H_TOTAL      64
`define JTMINI_H_VIS        48
`define JTMINI_V_TOTAL      20
`define JTMINI_V_VIS        16
`define JTMINI_HS_START     52
`define JTMINI_HS_LEN       4
`define JTMINI_VS_LINE      17

// System clocks per pixel
`define JTMINI_PXL_DIV      4

// Memory map: bitmap in words, palette in download bytes (32-byte aligned)
`define JTMINI_GFX_BASE     16'h0080
`define JTMINI_LINE_WORDS   12
`define JTMINI_PAL_START    17'h00400
`define JTMINI_SDRAM_LAT    4

`endif

//--- logic/jtmini_pkg.sv
// Shared vector types and the bank arbiter FSM encoding; widths must track jtmini_consts.svh
package jtmini_pkg;

    // SDRAM bank 0, 16-bit words
    typedef logic [15:0] sdram_addr_t;
    typedef logic [15:0] sdram_data_t;

    // Byte address of the download stream
    typedef logic [16:0] ioctl_addr_t;

    // Palette index and video counters
    typedef logic [ 3:0] pixel_t;
    typedef logic [ 5:0] hpos_t;
    typedef logic [ 4:0] vpos_t;

    // Output channel and RGB 4:4:4 palette entry, red in the top nibble
    typedef logic [ 7:0] colour_t;
    typedef logic [11:0] pal_entry_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_WAIT
    } arb_state_t;

endpackage

//--- logic/jtmini_vtimer.sv
// Video timer on one clock; line_start comes one clock after the pxl_cen that wraps hdump
`timescale 1ns/10ps
`include "jtmini_consts.svh"

module jtmini_vtimer(
    input                       clk,
    input                       rst,
    output                      pxl_cen,
    output logic                line_start,
    output jtmini_pkg::hpos_t   hdump,
    output jtmini_pkg::vpos_t   vdump,
    output jtmini_pkg::vpos_t   vrender,
    output                      HB,
    output                      VB,
    output                      HS,
    output                      VS
);

localparam int CEN_W = $clog2(`JTMINI_PXL_DIV);
localparam logic [CEN_W-1:0] CEN_LAST = CEN_W'(`JTMINI_PXL_DIV - 1);
localparam jtmini_pkg::hpos_t H_LAST   = 6'(`JTMINI_H_TOTAL - 1);
localparam jtmini_pkg::hpos_t H_VIS    = 6'(`JTMINI_H_VIS);
localparam jtmini_pkg::hpos_t HS_START = 6'(`JTMINI_HS_START);
localparam jtmini_pkg::hpos_t HS_END   = 6'(`JTMINI_HS_START + `JTMINI_HS_LEN);
localparam jtmini_pkg::vpos_t V_LAST   = 5'(`JTMINI_V_TOTAL - 1);
localparam jtmini_pkg::vpos_t V_VIS    = 5'(`JTMINI_V_VIS);
localparam jtmini_pkg::vpos_t VS_LINE  = 5'(`JTMINI_VS_LINE);

logic [CEN_W-1:0] cen_cnt;

assign pxl_cen = cen_cnt == CEN_LAST;

always_ff @(posedge clk) begin
    if (rst) begin
        cen_cnt    <= '0;
        hdump      <= '0;
        vdump      <= '0;
        line_start <= 1'b0;
    end else begin
        cen_cnt    <= pxl_cen ? '0 : cen_cnt + 1'd1;
        // Pulse lands once vdump already holds the new line
        line_start <= pxl_cen && hdump == H_LAST;
        if (pxl_cen) begin
            if (hdump == H_LAST) begin
                hdump <= '0;
                vdump <= vdump == V_LAST ? '0 : vdump + 5'd1;
            end else begin
                hdump <= hdump + 6'd1;
            end
        end
    end
end

// Line being fetched, shown from the next line start
assign vrender = vdump == V_LAST ? 5'd0 : vdump + 5'd1;

assign HB = hdump >= H_VIS;
assign VB = vdump >= V_VIS;
assign HS = hdump >= HS_START && hdump < HS_END;
assign VS = vdump == VS_LINE;

// Buffer swap lands before pixel 0 of the line is sampled
swap_before_first_pixel: assert property (@(posedge clk) disable iff (rst)
    line_start |-> hdump == '0 && !pxl_cen);

endmodule

//--- logic/jtmini_sdram.sv
// Bank 0 arbiter; ioctl bytes must be spaced so a word is never completed while a write is still pending
`timescale 1ns/10ps
`include "jtmini_consts.svh"

module jtmini_sdram(
    input                           clk,
    input                           rst,
    // Download
    input                           downloading,
    input  jtmini_pkg::ioctl_addr_t ioctl_addr,
    input  [ 7:0]                   ioctl_data,
    input                           ioctl_wr,
    output                          dwnld_busy,
    output logic                    pal_we,
    output jtmini_pkg::pixel_t      pal_idx,
    output jtmini_pkg::pal_entry_t  pal_data,
    // Main ROM
    input                           main_rom_cs,
    input  jtmini_pkg::sdram_addr_t main_rom_addr,
    output jtmini_pkg::sdram_data_t main_rom_data,
    output                          main_rom_ok,
    // Graphics
    input                           rom0_cs,
    input  jtmini_pkg::sdram_addr_t rom0_addr,
    output jtmini_pkg::sdram_data_t rom0_data,
    output                          rom0_ok,
    // Bank 0
    output jtmini_pkg::sdram_addr_t ba0_addr,
    output logic                    ba0_rd,
    output logic                    ba0_wr,
    output jtmini_pkg::sdram_data_t ba0_din,
    output [ 1:0]                   ba0_din_m,
    input                           ba0_ack,
    input                           ba0_rdy,
    input  jtmini_pkg::sdram_data_t data_read
);

jtmini_pkg::arb_state_t  state;
jtmini_pkg::sdram_addr_t wr_addr, main_addr_c, rom0_addr_c;
jtmini_pkg::sdram_data_t wr_data;
logic [7:0] low_byte;
logic       wr_pend, main_valid, rom0_valid, serve_rom0;

wire pal_region = ioctl_addr >= `JTMINI_PAL_START;
wire wr_done    = state == jtmini_pkg::ARB_REQ && ba0_ack && ba0_wr;

assign dwnld_busy  = downloading | wr_pend;
// Both bytes always written
assign ba0_din_m   = 2'b00;

assign main_rom_ok = main_rom_cs && main_valid && main_rom_addr == main_addr_c;
assign rom0_ok     = rom0_cs && rom0_valid && rom0_addr == rom0_addr_c;

// Byte packer, little endian
always_ff @(posedge clk) begin
    if (rst) begin
        pal_we  <= 1'b0;
        wr_pend <= 1'b0;
    end else begin
        pal_we <= 1'b0;
        if (wr_done) wr_pend <= 1'b0;
        if (ioctl_wr) begin
            if (!ioctl_addr[0]) begin
                low_byte <= ioctl_data;
            end else if (pal_region) begin
                pal_we   <= 1'b1;
                pal_idx  <= ioctl_addr[4:1];
                pal_data <= {ioctl_data[3:0], low_byte};
            end else begin
                wr_pend <= 1'b1;
                wr_addr <= ioctl_addr[16:1];
                wr_data <= {ioctl_data, low_byte};
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= jtmini_pkg::ARB_IDLE;
        ba0_rd     <= 1'b0;
        ba0_wr     <= 1'b0;
        main_valid <= 1'b0;
        rom0_valid <= 1'b0;
        serve_rom0 <= 1'b0;
    end else begin
        case (state)
            jtmini_pkg::ARB_IDLE: begin
                // Download first, then graphics, then main ROM
                if (wr_pend) begin
                    ba0_wr     <= 1'b1;
                    ba0_addr   <= wr_addr;
                    ba0_din    <= wr_data;
                    main_valid <= 1'b0;
                    rom0_valid <= 1'b0;
                    serve_rom0 <= 1'b0;
                    state      <= jtmini_pkg::ARB_REQ;
                end else if (rom0_cs && !rom0_ok) begin
                    ba0_rd     <= 1'b1;
                    ba0_addr   <= rom0_addr;
                    serve_rom0 <= 1'b1;
                    state      <= jtmini_pkg::ARB_REQ;
                end else if (main_rom_cs && !main_rom_ok) begin
                    ba0_rd     <= 1'b1;
                    ba0_addr   <= main_rom_addr;
                    serve_rom0 <= 1'b0;
                    state      <= jtmini_pkg::ARB_REQ;
                end
            end
            jtmini_pkg::ARB_REQ: begin
                if (ba0_ack) begin
                    ba0_rd <= 1'b0;
                    ba0_wr <= 1'b0;
                    state  <= ba0_wr ? jtmini_pkg::ARB_IDLE : jtmini_pkg::ARB_WAIT;
                end
            end
            jtmini_pkg::ARB_WAIT: begin
                if (ba0_rdy) begin
                    if (serve_rom0) begin
                        rom0_data   <= data_read;
                        rom0_addr_c <= ba0_addr;
                        rom0_valid  <= 1'b1;
                    end else begin
                        main_rom_data <= data_read;
                        main_addr_c   <= ba0_addr;
                        main_valid    <= 1'b1;
                    end
                    state <= jtmini_pkg::ARB_IDLE;
                end
            end
            default: state <= jtmini_pkg::ARB_IDLE;
        endcase
    end
end

no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst) !(ba0_rd && ba0_wr));

// Read data only comes back while no other request is on the bank
one_outstanding: assert property (@(posedge clk) disable iff (rst)
    ba0_rdy |-> !(ba0_rd || ba0_wr));

endmodule

//--- logic/jtmini_obj_fetch.sv
// Line fetcher; expects the arbiter to return LINE_WORDS words well inside one line period
`timescale 1ns/10ps
`include "jtmini_consts.svh"

module jtmini_obj_fetch(
    input                           clk,
    input                           rst,
    input                           line_start,
    input  jtmini_pkg::vpos_t       vrender,
    // Graphics ROM client
    output                          rom0_cs,
    output jtmini_pkg::sdram_addr_t rom0_addr,
    input                           rom0_ok,
    input  jtmini_pkg::sdram_data_t rom0_data,
    // Line buffer write side
    output logic                    buf_we,
    output logic [ 3:0]             buf_word,
    output jtmini_pkg::sdram_data_t buf_data
);

localparam logic [3:0] LAST_WORD = 4'(`JTMINI_LINE_WORDS - 1);

jtmini_pkg::sdram_addr_t line_base;
logic [3:0] word;
logic       busy;

assign rom0_cs   = busy;
assign rom0_addr = line_base + {12'd0, word};

always_ff @(posedge clk) begin
    if (rst) begin
        busy   <= 1'b0;
        word   <= 4'd0;
        buf_we <= 1'b0;
    end else begin
        buf_we <= 1'b0;
        if (line_start) begin
            busy      <= 1'b1;
            word      <= 4'd0;
            line_base <= `JTMINI_GFX_BASE + 16'(vrender) * 16'(`JTMINI_LINE_WORDS);
        end else if (busy && rom0_ok) begin
            // Four pixels per word go out in one write
            buf_we   <= 1'b1;
            buf_word <= word;
            buf_data <= rom0_data;
            word     <= word + 4'd1;
            if (word == LAST_WORD) busy <= 1'b0;
        end
    end
end

// Fetch for the line is over before the halves swap
fetch_in_time: assert property (@(posedge clk) disable iff (rst) line_start |-> !busy);

endmodule

//--- logic/jtmini_linebuf.sv
// Double line buffer of 4bpp pixels; reads are combinational from the half on display
`timescale 1ns/10ps
`include "jtmini_consts.svh"

module jtmini_linebuf(
    input                           clk,
    input                           rst,
    input                           line_start,
    // Write side, one word of four pixels
    input                           buf_we,
    input  [ 3:0]                   buf_word,
    input  jtmini_pkg::sdram_data_t buf_data,
    // Read side
    input  jtmini_pkg::hpos_t       rd_pos,
    output jtmini_pkg::pixel_t      rd_pixel
);

localparam int WORDS = `JTMINI_H_TOTAL / 4;

// Both halves in one array, half select in the top address bit
jtmini_pkg::sdram_data_t mem [2*WORDS];
jtmini_pkg::sdram_data_t rd_word;
logic disp_half;

always_ff @(posedge clk) begin
    if (rst) begin
        disp_half <= 1'b0;
    end else if (line_start) begin
        disp_half <= ~disp_half;
    end
end

// Fetcher fills the half not on screen
always_ff @(posedge clk) begin
    if (buf_we) begin
        mem[{~disp_half, buf_word}] <= buf_data;
    end
end

assign rd_word  = mem[{disp_half, rd_pos[5:2]}];

// Low nibble is the leftmost pixel
assign rd_pixel = rd_word[{rd_pos[1:0], 2'b00} +: 4];

endmodule

//--- logic/jtmini_colmix.sv
// Colour mixer; palette writes may happen at any time and show up on the next lookup
`timescale 1ns/10ps

module jtmini_colmix(
    input                           clk,
    input                           rst,
    input                           pxl_cen,
    input                           HB,
    input                           VB,
    input  jtmini_pkg::pixel_t      pixel,
    // Palette download
    input                           pal_we,
    input  jtmini_pkg::pixel_t      pal_idx,
    input  jtmini_pkg::pal_entry_t  pal_data,
    // Video out, one pixel behind hdump
    output jtmini_pkg::colour_t     red,
    output jtmini_pkg::colour_t     green,
    output jtmini_pkg::colour_t     blue,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly
);

jtmini_pkg::pal_entry_t pal [16];
jtmini_pkg::pal_entry_t entry;

wire blank = HB | VB;

always_ff @(posedge clk) begin
    if (pal_we) pal[pal_idx] <= pal_data;
end

assign entry = pal[pixel];

always_ff @(posedge clk) begin
    if (rst) begin
        red      <= 8'd0;
        green    <= 8'd0;
        blue     <= 8'd0;
        LHBL_dly <= 1'b0;
        LVBL_dly <= 1'b0;
    end else if (pxl_cen) begin
        // Nibble replicated to fill the channel
        red      <= blank ? 8'd0 : {2{entry[11:8]}};
        green    <= blank ? 8'd0 : {2{entry[ 7:4]}};
        blue     <= blank ? 8'd0 : {2{entry[ 3:0]}};
        LHBL_dly <= ~HB;
        LVBL_dly <= ~VB;
    end
end

endmodule

//--- logic/jtmini_game.sv
// Board top on a single clock; no CPU, the main ROM port is driven from outside the board
`timescale 1ns/10ps

module jtmini_game(
    input                           clk,
    input                           rst,
    output                          pxl_cen,
    // Video
    output jtmini_pkg::colour_t     red,
    output jtmini_pkg::colour_t     green,
    output jtmini_pkg::colour_t     blue,
    output                          LHBL_dly,
    output                          LVBL_dly,
    output                          HS,
    output                          VS,
    // ROM download
    input                           downloading,
    output                          dwnld_busy,
    input  jtmini_pkg::ioctl_addr_t ioctl_addr,
    input  [ 7:0]                   ioctl_data,
    input                           ioctl_wr,
    // Main ROM client
    input                           main_rom_cs,
    input  jtmini_pkg::sdram_addr_t main_rom_addr,
    output jtmini_pkg::sdram_data_t main_rom_data,
    output                          main_rom_ok,
    // Bank 0
    output jtmini_pkg::sdram_addr_t ba0_addr,
    output                          ba0_rd,
    output                          ba0_wr,
    output jtmini_pkg::sdram_data_t ba0_din,
    output [ 1:0]                   ba0_din_m,
    input                           ba0_ack,
    input                           ba0_rdy,
    input  jtmini_pkg::sdram_data_t data_read
);

wire                     HB, VB, line_start;
jtmini_pkg::hpos_t       hdump;
jtmini_pkg::vpos_t       vrender;
wire                     rom0_cs, rom0_ok, buf_we, pal_we;
jtmini_pkg::sdram_addr_t rom0_addr;
jtmini_pkg::sdram_data_t rom0_data, buf_data;
wire [ 3:0]              buf_word;
jtmini_pkg::pixel_t      pixel, pal_idx;
jtmini_pkg::pal_entry_t  pal_data;

jtmini_vtimer u_vtimer(
    .clk        ( clk           ),
    .rst        ( rst           ),
    .pxl_cen    ( pxl_cen       ),
    .line_start ( line_start    ),
    .hdump      ( hdump         ),
    .vdump      (               ),
    .vrender    ( vrender       ),
    .HB         ( HB            ),
    .VB         ( VB            ),
    .HS         ( HS            ),
    .VS         ( VS            )
);

jtmini_sdram u_sdram(
    .clk          ( clk           ),
    .rst          ( rst           ),
    .downloading  ( downloading   ),
    .ioctl_addr   ( ioctl_addr    ),
    .ioctl_data   ( ioctl_data    ),
    .ioctl_wr     ( ioctl_wr      ),
    .dwnld_busy   ( dwnld_busy    ),
    .pal_we       ( pal_we        ),
    .pal_idx      ( pal_idx       ),
    .pal_data     ( pal_data      ),
    .main_rom_cs  ( main_rom_cs   ),
    .main_rom_addr( main_rom_addr ),
    .main_rom_data( main_rom_data ),
    .main_rom_ok  ( main_rom_ok   ),
    .rom0_cs      ( rom0_cs       ),
    .rom0_addr    ( rom0_addr     ),
    .rom0_data    ( rom0_data     ),
    .rom0_ok      ( rom0_ok       ),
    .ba0_addr     ( ba0_addr      ),
    .ba0_rd       ( ba0_rd        ),
    .ba0_wr       ( ba0_wr        ),
    .ba0_din      ( ba0_din       ),
    .ba0_din_m    ( ba0_din_m     ),
    .ba0_ack      ( ba0_ack       ),
    .ba0_rdy      ( ba0_rdy       ),
    .data_read    ( data_read     )
);

jtmini_obj_fetch u_fetch(
    .clk        ( clk           ),
    .rst        ( rst           ),
    .line_start ( line_start    ),
    .vrender    ( vrender       ),
    .rom0_cs    ( rom0_cs       ),
    .rom0_addr  ( rom0_addr     ),
    .rom0_ok    ( rom0_ok       ),
    .rom0_data  ( rom0_data     ),
    .buf_we     ( buf_we        ),
    .buf_word   ( buf_word      ),
    .buf_data   ( buf_data      )
);

jtmini_linebuf u_linebuf(
    .clk        ( clk           ),
    .rst        ( rst           ),
    .line_start ( line_start    ),
    .buf_we     ( buf_we        ),
    .buf_word   ( buf_word      ),
    .buf_data   ( buf_data      ),
    .rd_pos     ( hdump         ),
    .rd_pixel   ( pixel         )
);

jtmini_colmix u_colmix(
    .clk        ( clk           ),
    .rst        ( rst           ),
    .pxl_cen    ( pxl_cen       ),
    .HB         ( HB            ),
    .VB         ( VB            ),
    .pixel      ( pixel         ),
    .pal_we     ( pal_we        ),
    .pal_idx    ( pal_idx       ),
    .pal_data   ( pal_data      ),
    .red        ( red           ),
    .green      ( green         ),
    .blue       ( blue          ),
    .LHBL_dly   ( LHBL_dly      ),
    .LVBL_dly   ( LVBL_dly      )
);

endmodule

//--- test/jtmini_clk.sv
// Testbench clock of 20 ns period; rst is held high for the first 3 rising edges
`timescale 1ns/10ps

module jtmini_clk(
    output logic clk,
    output logic rst
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
end

endmodule

//--- test/jtmini_sdram_model.sv
// SDRAM bank model; ack one clock after a request, read data JTMINI_SDRAM_LAT clocks after ack
`timescale 1ns/10ps
`include "jtmini_consts.svh"

module jtmini_sdram_model(
    input                           clk,
    input                           rst,
    input  jtmini_pkg::sdram_addr_t ba0_addr,
    input                           ba0_rd,
    input                           ba0_wr,
    input  jtmini_pkg::sdram_data_t ba0_din,
    input  [ 1:0]                   ba0_din_m,
    output logic                    ba0_ack,
    output logic                    ba0_rdy,
    output jtmini_pkg::sdram_data_t data_read
);

jtmini_pkg::sdram_data_t mem [65536];
jtmini_pkg::sdram_addr_t addr_l;
logic [2:0] cnt;
logic       busy;

// Fill depends on the whole address
initial begin
    for (int i = 0; i < 65536; i++) mem[i] = 16'(i) ^ 16'h5a3c;
end

always @(posedge clk) begin
    if (rst) begin
        ba0_ack   <= 1'b0;
        ba0_rdy   <= 1'b0;
        busy      <= 1'b0;
        cnt       <= 3'd0;
        data_read <= 16'd0;
    end else begin
        ba0_ack <= 1'b0;
        ba0_rdy <= 1'b0;
        if (busy) begin
            if (cnt == 3'd1) begin
                ba0_rdy   <= 1'b1;
                data_read <= mem[addr_l];
                busy      <= 1'b0;
            end
            cnt <= cnt - 3'd1;
        end else if ((ba0_rd || ba0_wr) && !ba0_ack) begin
            ba0_ack <= 1'b1;
            addr_l  <= ba0_addr;
            if (ba0_wr) begin
                // Mask bit low means the byte is written
                if (!ba0_din_m[0]) mem[ba0_addr][7:0]  <= ba0_din[7:0];
                if (!ba0_din_m[1]) mem[ba0_addr][15:8] <= ba0_din[15:8];
            end else begin
                busy <= 1'b1;
                cnt  <= 3'(`JTMINI_SDRAM_LAT);
            end
        end
    end
end

endmodule

//--- test/jtmini_tb.sv
// Directed testbench for jtmini_game; bytes are sent 16 clocks apart so the arbiter keeps up
`timescale 1ns/10ps
`include "jtmini_consts.svh"

module jtmini_tb;

localparam int BMP_WORDS  = `JTMINI_GFX_BASE + `JTMINI_V_TOTAL * `JTMINI_LINE_WORDS;
localparam int DL_BYTES   = 2 * BMP_WORDS;
localparam int BYTE_CLKS  = 16;
localparam int FRAME_CLKS = `JTMINI_H_TOTAL * `JTMINI_V_TOTAL * `JTMINI_PXL_DIV;
localparam int VIS_PIXELS = `JTMINI_H_VIS * `JTMINI_V_VIS;
// About 8 frames plus the download, rounded up
localparam int MAX_CYCLES = 60000;

wire clk, rst, pxl_cen, dwnld_busy, main_rom_ok, LHBL_dly, LVBL_dly, HS, VS;
wire ba0_rd, ba0_wr, ba0_ack, ba0_rdy;
wire [1:0] ba0_din_m;
jtmini_pkg::colour_t     red, green, blue;
jtmini_pkg::sdram_addr_t ba0_addr;
jtmini_pkg::sdram_data_t ba0_din, data_read, main_rom_data;

logic                    downloading, ioctl_wr, main_rom_cs;
jtmini_pkg::ioctl_addr_t ioctl_addr;
logic [7:0]              ioctl_data;
jtmini_pkg::sdram_addr_t main_rom_addr;

logic [7:0]             rom_bytes [DL_BYTES];
jtmini_pkg::pal_entry_t pal_ref [16];
jtmini_pkg::colour_t    cap_r [VIS_PIXELS];
jtmini_pkg::colour_t    cap_g [VIS_PIXELS];
jtmini_pkg::colour_t    cap_b [VIS_PIXELS];
int errors, checks, tests, cycles, cap_count;
logic cap_done;

jtmini_clk clk_gen(.clk(clk), .rst(rst));

jtmini_sdram_model sdram_model_inst(
    .clk(clk), .rst(rst), .ba0_addr(ba0_addr), .ba0_rd(ba0_rd), .ba0_wr(ba0_wr),
    .ba0_din(ba0_din), .ba0_din_m(ba0_din_m), .ba0_ack(ba0_ack), .ba0_rdy(ba0_rdy),
    .data_read(data_read)
);

jtmini_game jtmini_game_inst(
    .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .red(red), .green(green), .blue(blue),
    .LHBL_dly(LHBL_dly), .LVBL_dly(LVBL_dly), .HS(HS), .VS(VS),
    .downloading(downloading), .dwnld_busy(dwnld_busy), .ioctl_addr(ioctl_addr),
    .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr), .main_rom_cs(main_rom_cs),
    .main_rom_addr(main_rom_addr), .main_rom_data(main_rom_data), .main_rom_ok(main_rom_ok),
    .ba0_addr(ba0_addr), .ba0_rd(ba0_rd), .ba0_wr(ba0_wr), .ba0_din(ba0_din),
    .ba0_din_m(ba0_din_m), .ba0_ack(ba0_ack), .ba0_rdy(ba0_rdy), .data_read(data_read)
);

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end
end

task automatic compare_data(input string what, input jtmini_pkg::sdram_data_t got,
                            input jtmini_pkg::sdram_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_colour(input string what, input jtmini_pkg::colour_t got,
                              input jtmini_pkg::colour_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic compare_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("%s: %s", name, errors == errors_before ? "pass" : "fail");
endtask

function automatic jtmini_pkg::sdram_data_t bitmap_word(input int a);
    return {rom_bytes[2*a+1], rom_bytes[2*a]};
endfunction

task automatic send_byte(input int addr, input logic [7:0] data);
    @(negedge clk);
    ioctl_addr = 17'(addr);
    ioctl_data = data;
    ioctl_wr   = 1'b1;
    @(negedge clk);
    ioctl_wr = 1'b0;
    repeat (BYTE_CLKS - 2) @(negedge clk);
endtask

task automatic main_read(input jtmini_pkg::sdram_addr_t a);
    @(negedge clk);
    main_rom_cs   = 1'b1;
    main_rom_addr = a;
    @(negedge clk);
    while (!main_rom_ok) @(negedge clk);
    compare_data("main rom data", main_rom_data, bitmap_word(int'(a)));
    // Same address keeps the cached word
    repeat (3) begin
        @(negedge clk);
        compare_flag("main rom ok held", main_rom_ok, 1'b1);
        compare_data("main rom data held", main_rom_data, bitmap_word(int'(a)));
    end
    main_rom_cs = 1'b0;
endtask

task automatic capture_frame();
    logic seen;
    seen      = 1'b0;
    cap_count = 0;
    @(negedge clk);
    while (LVBL_dly) @(negedge clk);
    while (!(seen && !LVBL_dly)) begin
        @(negedge clk);
        if (LVBL_dly) seen = 1'b1;
        if (pxl_cen && LHBL_dly && LVBL_dly) begin
            if (cap_count < VIS_PIXELS) begin
                cap_r[cap_count] = red;
                cap_g[cap_count] = green;
                cap_b[cap_count] = blue;
            end
            cap_count++;
        end
    end
    cap_done = 1'b1;
endtask

task automatic check_frame();
    int x, y, a;
    jtmini_pkg::sdram_data_t w;
    jtmini_pkg::pixel_t nib;
    jtmini_pkg::pal_entry_t e;
    compare_count("visible pixels", cap_count, VIS_PIXELS);
    for (int k = 0; k < VIS_PIXELS && k < cap_count; k++) begin
        x   = k % `JTMINI_H_VIS;
        y   = k / `JTMINI_H_VIS;
        a   = `JTMINI_GFX_BASE + y * `JTMINI_LINE_WORDS + x / 4;
        w   = bitmap_word(a);
        nib = w[(x % 4) * 4 +: 4];
        e   = pal_ref[nib];
        compare_colour("red",   cap_r[k], {2{e[11:8]}});
        compare_colour("green", cap_g[k], {2{e[7:4]}});
        compare_colour("blue",  cap_b[k], {2{e[3:0]}});
    end
endtask

task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk);
    compare_flag("ba0_rd", ba0_rd, 1'b0);
    compare_flag("ba0_wr", ba0_wr, 1'b0);
    compare_flag("dwnld_busy", dwnld_busy, 1'b0);
    compare_flag("main_rom_ok", main_rom_ok, 1'b0);
    compare_flag("HS", HS, 1'b0);
    compare_flag("VS", VS, 1'b0);
    report_test("reset state", e0);
endtask

task automatic test_download();
    int e0;
    e0 = errors;
    @(negedge clk);
    downloading = 1'b1;
    @(negedge clk);
    compare_flag("dwnld_busy while downloading", dwnld_busy, 1'b1);
    for (int i = 0; i < DL_BYTES; i++) send_byte(i, rom_bytes[i]);
    // Palette entry i sits at byte pair PAL_START + 2i
    for (int i = 0; i < 16; i++) begin
        send_byte(int'(`JTMINI_PAL_START) + 2 * i, pal_ref[i][7:0]);
        send_byte(int'(`JTMINI_PAL_START) + 2 * i + 1, {4'h0, pal_ref[i][11:8]});
    end
    @(negedge clk);
    downloading = 1'b0;
    @(negedge clk);
    while (dwnld_busy) @(negedge clk);
    for (int a = 0; a < BMP_WORDS; a++) begin
        compare_data("sdram word", sdram_model_inst.mem[a], bitmap_word(a));
    end
    report_test("download", e0);
endtask

task automatic test_main_rom();
    int e0;
    e0 = errors;
    for (int i = 0; i < 16; i++) main_read(16'($urandom % BMP_WORDS));
    report_test("main rom reads", e0);
endtask

task automatic test_video();
    int e0;
    e0 = errors;
    capture_frame();
    check_frame();
    report_test("palette and video", e0);
endtask

task automatic test_contention();
    int e0;
    e0       = errors;
    cap_done = 1'b0;
    fork
        capture_frame();
        while (!cap_done) main_read(16'($urandom % BMP_WORDS));
    join
    check_frame();
    report_test("contention", e0);
endtask

task automatic test_sync();
    int e0, hs_n, vs_n;
    logic hs_p, vs_p;
    e0   = errors;
    hs_n = 0;
    vs_n = 0;
    @(negedge clk);
    vs_p = VS;
    @(negedge clk);
    while (!(VS && !vs_p)) begin
        vs_p = VS;
        @(negedge clk);
    end
    hs_p = HS;
    vs_p = VS;
    // Window of one frame ends on the next VS rise
    repeat (FRAME_CLKS) begin
        @(negedge clk);
        if (HS && !hs_p) hs_n++;
        if (VS && !vs_p) vs_n++;
        hs_p = HS;
        vs_p = VS;
    end
    compare_count("HS pulses", hs_n, `JTMINI_V_TOTAL);
    compare_count("VS pulses", vs_n, 1);
    report_test("sync", e0);
endtask

initial begin
    int seed;
    downloading   = 1'b0;
    ioctl_wr      = 1'b0;
    ioctl_addr    = '0;
    ioctl_data    = 8'd0;
    main_rom_cs   = 1'b0;
    main_rom_addr = '0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    cycles        = 0;
    cap_done      = 1'b0;
    seed          = $urandom(57);
    for (int i = 0; i < DL_BYTES; i++) rom_bytes[i] = 8'($urandom);
    for (int i = 0; i < 16; i++) pal_ref[i] = 12'($urandom);
    @(negedge rst);
    test_reset();
    test_download();
    test_main_rom();
    test_video();
    test_contention();
    test_sync();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

//--- verilog.f
+incdir+logic
logic/jtmini_pkg.sv
logic/jtmini_vtimer.sv
logic/jtmini_sdram.sv
logic/jtmini_obj_fetch.sv
logic/jtmini_linebuf.sv
logic/jtmini_colmix.sv
logic/jtmini_game.sv
test/jtmini_clk.sv
test/jtmini_sdram_model.sv
test/jtmini_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = jtmini_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
